// File: hdl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_dpath_cfg.svh"

// E stage ALU, fully combinational
module ex_alu (
   input  ex_data_pkg::ex_word_t    rs1,
   input  ex_data_pkg::ex_word_t    rs2,
   input  ex_ctl_pkg::ex_alu_ctl_t  ctl,
   output ex_data_pkg::ex_word_t    result,  // Selected by ctl.op
   output ex_data_pkg::ex_word_t    sum,     // Adder output for every op
   output ex_data_pkg::ex_flags_t   flags
);

   logic                    sub_op;
   ex_data_pkg::ex_word_t   add_b;      // Second adder input
   logic [`EX_XLEN:0]       add_full;   // Carry in top bit
   logic                    cmp_gt;
   logic                    cmp_eq;
   logic                    cmp_lt;
   ex_data_pkg::ex_word_t   cmp_out;    // Three-way constant
   logic [`EX_SHAMT_W-1:0]  shamt;
   ex_data_pkg::ex_word_t   shift_out;

   // Adder
   assign sub_op   = (ctl.op == ex_ctl_pkg::OP_SUB);
   assign add_b    = sub_op ? ~rs2 : rs2;  // Invert for subtract
   assign add_full = {1'b0, rs1} + {1'b0, add_b}
                   + {{`EX_XLEN{1'b0}}, ctl.carry_in};
   assign sum      = add_full[`EX_XLEN-1:0];

   // Comparator
   always_comb begin
      if (ctl.sign) begin
         cmp_gt = ($signed(rs1) > $signed(rs2));
         cmp_lt = ($signed(rs1) < $signed(rs2));
      end else begin
         cmp_gt = (rs1 > rs2);
         cmp_lt = (rs1 < rs2);
      end
   end

   assign cmp_eq = (rs1 == rs2);  // Sign does not matter here

   // +1 for gt, -1 for lt, else 0
   always_comb begin
      if (cmp_gt) begin
         cmp_out = ex_data_pkg::ex_word_t'(1);
      end else if (cmp_lt) begin
         cmp_out = '1;
      end else begin
         cmp_out = '0;
      end
   end

   // Shifter uses low bits of rs2 only
   assign shamt = rs2[`EX_SHAMT_W-1:0];

   always_comb begin
      if (ctl.op == ex_ctl_pkg::OP_SHL) begin
         shift_out = rs1 << shamt;
      end else if (ctl.sign) begin
         shift_out = $signed(rs1) >>> shamt;  // Sign fill
      end else begin
         shift_out = rs1 >> shamt;
      end
   end

   // Result selection
   always_comb begin
      case (ctl.op)
         ex_ctl_pkg::OP_ADD: result = sum;
         ex_ctl_pkg::OP_SUB: result = sum;
         ex_ctl_pkg::OP_AND: result = rs1 & rs2;
         ex_ctl_pkg::OP_OR:  result = rs1 | rs2;
         ex_ctl_pkg::OP_XOR: result = rs1 ^ rs2;
         ex_ctl_pkg::OP_SHL: result = shift_out;
         ex_ctl_pkg::OP_SHR: result = shift_out;
         ex_ctl_pkg::OP_CMP: result = cmp_out;
         ex_ctl_pkg::OP_PASS: result = rs1;
         default:            result = rs1;  // Reserved codes pass rs1
      endcase
   end

   assign flags = '{gt: cmp_gt, eq: cmp_eq, lt: cmp_lt, carry: add_full[`EX_XLEN]};

endmodule

`default_nettype wire

// File: hdl/ex_ctl_pkg.sv
`default_nettype none

package ex_ctl_pkg;

   // Operand source select, sampled in R and used in E
   typedef enum logic [2:0] {
      SRC_REG    = 3'd0,  // Register unit value
      SRC_FWD_C  = 3'd1,  // C stage result
      SRC_FWD_W  = 3'd2,  // W stage result
      SRC_FWD_W1 = 3'd3,  // W1 stage result
      SRC_HOLD   = 3'd4   // Replay last cycle's operand
   } ex_opnd_src_e;

   // ALU operation
   typedef enum logic [3:0] {
      OP_PASS = 4'd0,  // rs1 through
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,  // rs1 + ~rs2 + carry_in
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_SHL  = 4'd6,
      OP_SHR  = 4'd7,  // Logical or arithmetic by sign
      OP_CMP  = 4'd8   // +1, 0 or -1
   } ex_alu_op_e;

   typedef struct packed {
      ex_alu_op_e op;
      logic       sign;      // Signed compare, arithmetic right shift
      logic       carry_in;  // Adder carry in
   } ex_alu_ctl_t;

   // Load buffer and DCU register controls
   typedef struct packed {
      logic buf_we;   // Capture dcu_data_c in load buffer
      logic data_we;  // Load dcu_data_w
      logic buf_sel;  // 1 selects the buffered word
   } ex_load_ctl_t;

endpackage

`default_nettype wire

// File: hdl/ex_data_pkg.sv
`default_nettype none

`include "ex_dpath_cfg.svh"

package ex_data_pkg;

   // One datapath word
   typedef logic [`EX_XLEN-1:0] ex_word_t;

   // Results visible to the operand selectors
   typedef struct packed {
      ex_word_t data_c;   // C stage, ALU or DCU word
      ex_word_t data_w;   // W stage, ALU or DCU word
      ex_word_t data_w1;  // W1 stage copy of data_w
   } ex_fwd_t;

   // Comparator and adder flags
   // gt/eq/lt are one-hot
   typedef struct packed {
      logic gt;     // rs1 > rs2
      logic eq;     // rs1 == rs2
      logic lt;     // rs1 < rs2
      logic carry;  // Adder carry out
   } ex_flags_t;

endpackage

`default_nettype wire

// File: hdl/ex_dpath_cfg.svh
`ifndef EX_DPATH_CFG_SVH
`define EX_DPATH_CFG_SVH

// Width of one datapath word
`define EX_XLEN    32

// Shift count width
// Covers shift amounts 0 to EX_XLEN-1
`define EX_SHAMT_W 5

`endif

// File: hdl/ex_dpath_top.sv
`timescale 1ns/1ps
`default_nettype none

// Execute stage datapath
module ex_dpath_top (
   input  logic                       clk,
   input  logic                       arst_n,
   input  ex_data_pkg::ex_word_t      rs1_in,      // Operand 1 from register unit
   input  ex_data_pkg::ex_word_t      rs2_in,      // Operand 2 from register unit
   input  ex_ctl_pkg::ex_opnd_src_e   rs1_src,     // R stage select
   input  ex_ctl_pkg::ex_opnd_src_e   rs2_src,
   input  ex_ctl_pkg::ex_alu_ctl_t    alu_ctl,     // E stage ALU control
   input  logic                       hold_e,
   input  logic                       hold_c,
   input  logic                       fwd_c_dcu,
   input  logic                       fwd_w_dcu,
   input  ex_data_pkg::ex_word_t      dcu_data_c,
   input  ex_ctl_pkg::ex_load_ctl_t   load_ctl,
   output ex_data_pkg::ex_word_t      rs1_out,     // E operands
   output ex_data_pkg::ex_word_t      rs2_out,
   output ex_data_pkg::ex_word_t      adder_out_e,
   output ex_data_pkg::ex_flags_t     flags_e,
   output ex_data_pkg::ex_word_t      alu_out_w,
   output ex_data_pkg::ex_word_t      dcu_data_w,
   output logic                       lock_bit
);

   ex_data_pkg::ex_fwd_t  fwd;       // Bundle back to both selectors
   ex_data_pkg::ex_word_t result_e;  // ALU result into C

   ex_operand_bypass u_rs1 (
      .clk     (clk),
      .arst_n  (arst_n),
      .hold_e  (hold_e),
      .src     (rs1_src),
      .reg_val (rs1_in),
      .fwd     (fwd),
      .opnd    (rs1_out)
   );

   ex_operand_bypass u_rs2 (
      .clk     (clk),
      .arst_n  (arst_n),
      .hold_e  (hold_e),
      .src     (rs2_src),
      .reg_val (rs2_in),
      .fwd     (fwd),
      .opnd    (rs2_out)
   );

   ex_alu u_alu (
      .rs1    (rs1_out),
      .rs2    (rs2_out),
      .ctl    (alu_ctl),
      .result (result_e),
      .sum    (adder_out_e),
      .flags  (flags_e)
   );

   ex_writeback_pipe u_wb (
      .clk        (clk),
      .arst_n     (arst_n),
      .hold_c     (hold_c),
      .result_e   (result_e),
      .fwd_c_dcu  (fwd_c_dcu),
      .fwd_w_dcu  (fwd_w_dcu),
      .dcu_data_c (dcu_data_c),
      .load_ctl   (load_ctl),
      .fwd        (fwd),
      .alu_out_w  (alu_out_w),
      .dcu_data_w (dcu_data_w),
      .lock_bit   (lock_bit)
   );

endmodule

`default_nettype wire

// File: hdl/ex_operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

// One E stage operand with its forwarding select
module ex_operand_bypass (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     hold_e,   // Freezes the select
   input  ex_ctl_pkg::ex_opnd_src_e src,      // R stage select
   input  ex_data_pkg::ex_word_t    reg_val,  // From register unit
   input  ex_data_pkg::ex_fwd_t     fwd,      // Later stage results
   output ex_data_pkg::ex_word_t    opnd
);

   ex_ctl_pkg::ex_opnd_src_e src_q;     // E stage select
   ex_data_pkg::ex_word_t    replay_q;  // Previous cycle's operand

   // Select moves R to E unless E is held
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         src_q <= ex_ctl_pkg::SRC_REG;
      end else if (!hold_e) begin
         src_q <= src;
      end
   end

   // Captures every cycle
   // Bubbled forward case replays this word
   always_ff @(posedge clk) begin
      replay_q <= opnd;
   end

   // Five way operand mux
   always_comb begin
      case (src_q)
         ex_ctl_pkg::SRC_FWD_C:  opnd = fwd.data_c;
         ex_ctl_pkg::SRC_FWD_W:  opnd = fwd.data_w;
         ex_ctl_pkg::SRC_FWD_W1: opnd = fwd.data_w1;
         ex_ctl_pkg::SRC_HOLD:   opnd = replay_q;
         ex_ctl_pkg::SRC_REG:    opnd = reg_val;
         default:                opnd = reg_val;  // Unused codes
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/ex_writeback_pipe.sv
`timescale 1ns/1ps
`default_nettype none

// C, W and W1 result stages plus the DCU load path
module ex_writeback_pipe (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       hold_c,      // Freezes C and W
   input  ex_data_pkg::ex_word_t      result_e,    // ALU result in E
   input  logic                       fwd_c_dcu,   // C stage forwards DCU word
   input  logic                       fwd_w_dcu,   // W stage forwards DCU word
   input  ex_data_pkg::ex_word_t      dcu_data_c,  // Load data in C
   input  ex_ctl_pkg::ex_load_ctl_t   load_ctl,
   output ex_data_pkg::ex_fwd_t       fwd,
   output ex_data_pkg::ex_word_t      alu_out_w,
   output ex_data_pkg::ex_word_t      dcu_data_w,
   output logic                       lock_bit     // Monitor lock bit
);

   ex_data_pkg::ex_word_t alu_out_c;    // E result in C
   ex_data_pkg::ex_word_t alu_out_c_d1; // C result in W
   ex_data_pkg::ex_word_t data_c;
   ex_data_pkg::ex_word_t data_w;
   ex_data_pkg::ex_word_t data_w1_q;
   ex_data_pkg::ex_word_t load_buf_q;   // Parked load word
   ex_data_pkg::ex_word_t load_mux;
   logic                  fwd_c_sel_q;
   logic                  fwd_w_sel_q;

   // Result stages advance unless C is held
   always_ff @(posedge clk) begin
      if (!hold_c) begin
         alu_out_c    <= result_e;
         alu_out_c_d1 <= alu_out_c;
      end
      data_w1_q <= data_w;  // W1 never holds
   end

   // Forwarding selects
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fwd_c_sel_q <= 1'b0;
         fwd_w_sel_q <= 1'b0;
      end else begin
         fwd_c_sel_q <= fwd_c_dcu;
         if (!hold_c) begin
            fwd_w_sel_q <= fwd_w_dcu;
         end
      end
   end

   assign data_c = fwd_c_sel_q ? dcu_data_w : alu_out_c;
   assign data_w = fwd_w_sel_q ? dcu_data_w : alu_out_c_d1;

   // Load buffer keeps a second load from overwriting the first
   always_ff @(posedge clk) begin
      if (load_ctl.buf_we) begin
         load_buf_q <= dcu_data_c;
      end
      if (load_ctl.data_we) begin
         dcu_data_w <= load_mux;
      end
   end

   assign load_mux = load_ctl.buf_sel ? load_buf_q : dcu_data_c;
   assign lock_bit = load_mux[0];  // Same cycle as the choice

   assign fwd       = '{data_c: data_c, data_w: data_w, data_w1: data_w1_q};
   assign alu_out_w = data_w;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the execute datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "Result: FAIL"
   exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
   echo "Result: FAIL, no summary in log"
   exit 1
fi
echo "Result: PASS"
exit 0

// File: sources.f
+incdir+hdl
hdl/ex_data_pkg.sv
hdl/ex_ctl_pkg.sv
hdl/ex_operand_bypass.sv
hdl/ex_alu.sv
hdl/ex_writeback_pipe.sv
hdl/ex_dpath_top.sv
testbench/ex_dpath_assertions.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: testbench/ex_dpath_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol rules on the execute datapath ports
module ex_dpath_assertions (
   input logic                     clk,
   input logic                     arst_n,
   input ex_data_pkg::ex_word_t    rs1_in,
   input ex_data_pkg::ex_word_t    rs1_out,
   input ex_data_pkg::ex_flags_t   flags_e,
   input logic                     hold_c,
   input ex_data_pkg::ex_word_t    alu_out_w,
   input ex_ctl_pkg::ex_load_ctl_t load_ctl,
   input ex_data_pkg::ex_word_t    dcu_data_w,
   input logic                     lock_bit
);

   int fail_cnt = 0;  // Read by tb_top

   flags_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot({flags_e.gt, flags_e.eq, flags_e.lt}))
      else begin
         fail_cnt++;
         $error("compare flags not one-hot");
      end

   // Select register comes out of reset at SRC_REG
   rs1_after_reset: assert property (@(posedge clk)
      $rose(arst_n) |-> rs1_out == rs1_in)
      else begin
         fail_cnt++;
         $error("rs1_out differs from rs1_in after reset");
      end

   // DCU word can still reach W under hold, so only ALU data is stable
   w_stable_on_hold: assert property (@(posedge clk) disable iff (!arst_n)
      hold_c && !load_ctl.data_we |=> $stable(alu_out_w))
      else begin
         fail_cnt++;
         $error("alu_out_w changed while hold_c was high");
      end

   lock_follows_load: assert property (@(posedge clk) disable iff (!arst_n)
      load_ctl.data_we && !load_ctl.buf_sel |=> dcu_data_w[0] == $past(lock_bit))
      else begin
         fail_cnt++;
         $error("lock_bit does not match loaded dcu_data_w bit 0");
      end

endmodule

bind ex_dpath_top ex_dpath_assertions u_assert (
   .clk        (clk),
   .arst_n     (arst_n),
   .rs1_in     (rs1_in),
   .rs1_out    (rs1_out),
   .flags_e    (flags_e),
   .hold_c     (hold_c),
   .alu_out_w  (alu_out_w),
   .load_ctl   (load_ctl),
   .dcu_data_w (dcu_data_w),
   .lock_bit   (lock_bit)
);

`default_nettype wire

// File: testbench/ex_dpath_testdata.txt
// tag ctl rs1_in rs2_in dcu_data_c exp_rs1 exp_rs2 exp_sum exp_alu_w exp_dcu_w
// tag: test[31:24] mask[23:16] flags{gt,eq,lt,carry}[7:4] lock[0]
// mask: 0 rs1 1 rs2 2 sum 3 flags 4 alu_w 5 dcu_w 6 lock
// ctl nibbles: rs1_src rs2_src op {sign,cin} {hold_e,hold_c} {fwd_c,fwd_w} {buf_we,we,sel}
01030000 00000000 12345678 9abcdef0 00000000 12345678 9abcdef0 00000000 00000000 00000000
01030000 00000000 00000001 ffffffff 00000000 00000001 ffffffff 00000000 00000000 00000000
021c0080 00010000 00000005 00000003 00000000 00000000 00000000 00000008 12345678 00000000
021c0090 00011000 ffffffff 00000001 00000000 00000000 00000000 00000001 00000001 00000000
021c0020 00021000 00000003 00000005 00000000 00000000 00000000 fffffffe 00000008 00000000
021c0030 00030000 f0f0ff00 ff00f0f0 00000000 00000000 00000000 eff1eff0 00000001 00000000
021c0030 00040000 f0f0ff00 ff00f0f0 00000000 00000000 00000000 eff1eff0 fffffffe 00000000
021c0030 00050000 f0f0ff00 ff00f0f0 00000000 00000000 00000000 eff1eff0 f000f000 00000000
021c0080 00060000 80000001 00000024 00000000 00000000 00000000 80000025 fff0fff0 00000000
021c0020 00072000 80000010 00000004 00000000 00000000 00000000 80000014 0ff00ff0 00000000
021c0080 00070000 80000010 00000004 00000000 00000000 00000000 80000014 00000010 00000000
021c0080 00000000 cafef00d 00000000 00000000 00000000 00000000 cafef00d f8000001 00000000
031c0030 00082000 ffffffff 00000001 00000000 00000000 00000000 00000000 08000001 00000000
031c0090 00080000 ffffffff 00000001 00000000 00000000 00000000 00000000 cafef00d 00000000
031c0040 00082000 00000007 00000007 00000000 00000000 00000000 0000000e ffffffff 00000000
031c0040 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 00000000
031c0080 00000000 11111111 00000000 00000000 00000000 00000000 11111111 00000000 00000000
04130000 01000000 22222222 00000000 00000000 22222222 00000000 00000000 00000000 00000000
04170000 03010000 99999999 00000001 00000000 22222222 00000001 22222223 11111111 00000000
04130000 04200000 aaaaaaaa bbbbbbbb 00000000 11111111 bbbbbbbb 00000000 22222222 00000000
04130000 00000000 33333333 44444444 00000000 11111111 22222223 00000000 22222223 00000000
04130000 00000000 55555555 66666666 00000000 55555555 66666666 00000000 11111111 00000000
05130000 01000200 77777777 00000000 00000000 77777777 00000000 00000000 11111111 00000000
05130000 00000000 88888888 00000000 00000000 88888888 00000000 00000000 55555555 00000000
05110000 00000100 99999999 00000000 00000000 99999999 00000000 00000000 77777777 00000000
05110000 00000100 aaaaaaaa 00000000 00000000 aaaaaaaa 00000000 00000000 77777777 00000000
05110000 00000000 bbbbbbbb 00000000 00000000 bbbbbbbb 00000000 00000000 77777777 00000000
05110000 00000000 cccccccc 00000000 00000000 cccccccc 00000000 00000000 88888888 00000000
05110000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bbbbbbbb 00000000
06400001 00000004 00000000 00000000 12340001 00000000 00000000 00000000 00000000 00000000
06400000 00000002 00000000 00000000 56780002 00000000 00000000 00000000 00000000 00000000
06600001 00000003 00000000 00000000 9abc0004 00000000 00000000 00000000 00000000 56780002
06600000 02000010 00000000 00000000 00000000 00000000 00000000 00000000 00000000 12340001
06310000 00100020 00000000 00000000 00000000 12340001 00000000 00000000 12340001 12340001
06130000 00000000 00000000 ffffffff 00000000 00000000 12340001 00000000 00000000 00000000
06110000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 12340001 00000000
// End marker
ff000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// File: testbench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Compares DUT outputs with the expected words of the current vector
module tb_checker (
   input  logic                   clk,
   input  logic                   check_en,  // Vector on the DUT is valid
   input  logic [9:0][31:0]       vec,       // Current data file line
   input  ex_data_pkg::ex_word_t  rs1_out,
   input  ex_data_pkg::ex_word_t  rs2_out,
   input  ex_data_pkg::ex_word_t  adder_out_e,
   input  ex_data_pkg::ex_flags_t flags_e,
   input  ex_data_pkg::ex_word_t  alu_out_w,
   input  ex_data_pkg::ex_word_t  dcu_data_w,
   input  logic                   lock_bit,
   output int                     err_count
);

   logic [7:0] test_id;
   logic [7:0] mask;  // One bit per checked output

   assign test_id = vec[0][31:24];
   assign mask    = vec[0][23:16];

   initial err_count = 0;

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: test %0d %s is %08h, expected %08h",
                  $time, test_id, name, got, exp);
         err_count = err_count + 1;
      end
   endtask

   // Outputs settle well before the falling edge
   always @(negedge clk) begin
      if (check_en) begin
         if (mask[0]) check_word("rs1_out", rs1_out, vec[5]);
         if (mask[1]) check_word("rs2_out", rs2_out, vec[6]);
         if (mask[2]) check_word("adder_out_e", adder_out_e, vec[7]);
         if (mask[3]) check_word("flags_e", {28'h0, flags_e}, {28'h0, vec[0][7:4]});
         if (mask[4]) check_word("alu_out_w", alu_out_w, vec[8]);
         if (mask[5]) check_word("dcu_data_w", dcu_data_w, vec[9]);
         if (mask[6]) check_word("lock_bit", {31'h0, lock_bit}, {31'h0, vec[0][0]});
      end
   end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free running clock and power-on reset
module tb_clock_gen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // Low for 4 rising edges, released on a falling edge
   initial begin
      arst_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

   localparam int MAX_VEC   = 64;
   localparam int VEC_WORDS = 10;  // Words per data file line

   logic                     clk;
   logic                     arst_n;
   ex_data_pkg::ex_word_t    rs1_in;
   ex_data_pkg::ex_word_t    rs2_in;
   ex_ctl_pkg::ex_opnd_src_e rs1_src;
   ex_ctl_pkg::ex_opnd_src_e rs2_src;
   ex_ctl_pkg::ex_alu_ctl_t  alu_ctl;
   logic                     hold_e;
   logic                     hold_c;
   logic                     fwd_c_dcu;
   logic                     fwd_w_dcu;
   ex_data_pkg::ex_word_t    dcu_data_c;
   ex_ctl_pkg::ex_load_ctl_t load_ctl;
   ex_data_pkg::ex_word_t    rs1_out;
   ex_data_pkg::ex_word_t    rs2_out;
   ex_data_pkg::ex_word_t    adder_out_e;
   ex_data_pkg::ex_flags_t   flags_e;
   ex_data_pkg::ex_word_t    alu_out_w;
   ex_data_pkg::ex_word_t    dcu_data_w;
   logic                     lock_bit;

   logic [31:0]              mem [0:MAX_VEC*VEC_WORDS-1];
   logic [9:0][31:0]         vec;        // Line under check
   logic                     check_en;
   int                       err_count;  // From tb_checker
   int                       n_vec = 0;
   int                       cycle_cnt = 0;
   int                       cycle_limit = 0;
   int                       tests_run = 0;
   int                       tests_failed = 0;
   int                       errs_before = 0;

   tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

   ex_dpath_top DUT (.*);

   tb_checker u_chk (
      .clk (clk), .check_en (check_en), .vec (vec),
      .rs1_out (rs1_out), .rs2_out (rs2_out), .adder_out_e (adder_out_e),
      .flags_e (flags_e), .alu_out_w (alu_out_w), .dcu_data_w (dcu_data_w),
      .lock_bit (lock_bit), .err_count (err_count)
   );

   // Control word layout is described in the data file
   task automatic apply_vector(input int idx);
      logic [31:0] ctl;
      ctl = mem[idx*VEC_WORDS+1];
      for (int w = 0; w < VEC_WORDS; w++) vec[w] <= mem[idx*VEC_WORDS+w];
      rs1_src    <= ex_ctl_pkg::ex_opnd_src_e'(ctl[26:24]);
      rs2_src    <= ex_ctl_pkg::ex_opnd_src_e'(ctl[22:20]);
      alu_ctl    <= '{op: ex_ctl_pkg::ex_alu_op_e'(ctl[19:16]), sign: ctl[13],
                      carry_in: ctl[12]};
      hold_e     <= ctl[9];
      hold_c     <= ctl[8];
      fwd_c_dcu  <= ctl[5];
      fwd_w_dcu  <= ctl[4];
      load_ctl   <= '{buf_we: ctl[2], data_we: ctl[1], buf_sel: ctl[0]};
      rs1_in     <= mem[idx*VEC_WORDS+2];
      rs2_in     <= mem[idx*VEC_WORDS+3];
      dcu_data_c <= mem[idx*VEC_WORDS+4];
      check_en   <= 1'b1;
   endtask

   task automatic report_test(input int idx);
      int errs;
      errs = err_count + DUT.u_assert.fail_cnt - errs_before;
      tests_run++;
      if (errs != 0) tests_failed++;
      $display("Test %0d: %s (%0d errors)", mem[idx*VEC_WORDS][31:24],
               (errs == 0) ? "pass" : "fail", errs);
      errs_before = err_count + DUT.u_assert.fail_cnt;
   endtask

   initial begin
      rs1_in = 32'h5a5a_c3c3;  // Nonzero so the reset select shows on rs1_out
      rs2_in = '0;
      rs1_src = ex_ctl_pkg::SRC_REG;
      rs2_src = ex_ctl_pkg::SRC_REG;
      alu_ctl = '{op: ex_ctl_pkg::OP_PASS, sign: 1'b0, carry_in: 1'b0};
      hold_e = 1'b0;
      hold_c = 1'b0;
      fwd_c_dcu = 1'b0;
      fwd_w_dcu = 1'b0;
      dcu_data_c = '0;
      load_ctl = '{buf_we: 1'b0, data_we: 1'b0, buf_sel: 1'b0};
      vec = '0;
      check_en = 1'b0;
      $readmemh("testbench/ex_dpath_testdata.txt", mem);
      while (n_vec < MAX_VEC && mem[n_vec*VEC_WORDS][31:24] != 8'hff) n_vec++;
      cycle_limit = 4 * n_vec + 50;
      wait (arst_n === 1'b1);
      for (int i = 0; i < n_vec; i++) begin
         @(posedge clk);
         // Previous line was checked at the last falling edge
         if (i > 0 && mem[i*VEC_WORDS][31:24] != mem[(i-1)*VEC_WORDS][31:24])
            report_test(i - 1);
         apply_vector(i);
      end
      @(posedge clk);
      check_en <= 1'b0;
      @(negedge clk);  // Last edge fully evaluated
      if (n_vec > 0) report_test(n_vec - 1);
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed,
               err_count + DUT.u_assert.fail_cnt);
      if (tests_failed == 0 && tests_run > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Run timed out after %0d cycles without finishing", cycle_cnt);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire
